//--- bench/board_assert.sv
`timescale 1ns/100ps

module board_assert
(
    input logic clk,
    input logic rst_n,
    input logic sio_clk,
    input logic sio_stb,
    input logic sio_oe,
    input logic reading,                           // Controller in its key read state
    input logic valid                              // Sample strobe
);

    // ------------------------------
    // TM1638 bus

    stb_falls_clock_high: assert property (@(posedge clk) disable iff (! rst_n)
        $fell (sio_stb) |-> sio_clk)
        else $error ("sio_stb fell while sio_clk was low");

    oe_released_in_read: assert property (@(posedge clk) disable iff (! rst_n)
        reading && ! sio_clk |-> ! sio_oe)
        else $error ("sio_oe high during a key read bit");

    // ------------------------------
    // Microphone strobe

    valid_one_cycle: assert property (@(posedge clk) disable iff (! rst_n)
        $rose (valid) |=> ! valid)
        else $error ("sample valid longer than one cycle");

endmodule

// Controller bus and receiver strobe, both seen from the board top
bind board_specific_top board_assert board_assert_inst
(
    .clk     ( clk                                    ),
    .rst_n   ( rst_n                                  ),
    .sio_clk ( sio_clk                                ),
    .sio_stb ( sio_stb                                ),
    .sio_oe  ( sio_oe                                 ),
    .reading ( i_ledkey.state == board_pkg::st_read   ),
    .valid   ( sample.valid                           )
);

//--- bench/board_tb.sv
`timescale 1ns/100ps

module board_tb;

    localparam int sio_div      = 2;
    localparam int sck_div      = 2;
    localparam int w_key        = 2;
    localparam int w_sw         = 4;
    localparam int w_led        = 8;
    localparam int n_tests      = 8;
    localparam int frame_clocks = 450 * sio_div;   // Upper bound of one TM1638 frame

    localparam logic [7:0] tm_write   = 8'h40;     // TM1638 protocol bytes
    localparam logic [7:0] tm_addr    = 8'hc0;
    localparam logic [7:0] tm_ctrl    = 8'h8f;
    localparam logic [7:0] tm_read    = 8'h42;
    localparam logic [7:0] seg_font [16] = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d,
                                             8'h7d, 8'h07, 8'h7f, 8'h6f, 8'h77, 8'h7c,
                                             8'h39, 8'h5e, 8'h79, 8'h71};

    logic               clk;
    logic               rst_n;
    logic [w_key - 1:0] key;
    logic [w_sw  - 1:0] sw;
    wire  [w_led - 1:0] led;
    wire                sio_clk;
    wire                sio_stb;
    wire                sio_data;
    wire                mic_sck;
    wire                mic_ws;
    wire                mic_lr;
    logic               mic_sd    = 1'b0;
    wire                mic_valid = board_specific_top_inst.i_microphone.valid_q;

    logic [23:0] mic_word;                         // Word the mic sends next
    logic [23:0] tx_word;
    logic        ws_prev  = 1'b0;
    int          mic_bit  = 100;                   // Large until the first left slot
    logic [7:0]  tm_keys;                          // Keys held on the TM1638 board
    logic [31:0] rd_word;
    logic [7:0]  rx_sh;
    int          rx_bits  = 0;
    int          rx_bytes = 0;
    int          win_idx  = 0;
    logic        win_open = 1'b0;
    logic        tm_drive = 1'b0;
    logic        tm_bit   = 1'b0;
    logic [7:0]  rx_q [$];
    logic [7:0]  frame_rx [$];                     // Bytes of the last whole frame
    int          win_len [4];
    event        frame_done;
    event        checked;
    logic        check_req = 1'b0;
    string       case_name;
    logic [23:0] exp_word;
    logic [7:0]  exp_keys;
    logic        exp_s0;

    assign sio_data = tm_drive ? tm_bit : 1'bz;

    tb_clock # (.period (20)) tb_clock_inst (.clk (clk));

    board_specific_top
    # (
        .clk_mhz  ( 50       ),
        .sio_div  ( sio_div  ),
        .sck_div  ( sck_div  ),
        .w_key    ( w_key    ),
        .w_sw     ( w_sw     ),
        .w_led    ( w_led    )
    )
    board_specific_top_inst
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   )
    );

    // ------------------------------
    // Reference and compare helpers

    task automatic check (input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display ("error %s: expected %0h, actual %0h", name, expected, actual);
            $display ("=== FAIL ===");
            $fatal (1, "mismatch in %s", name);
        end
    endtask

    // Display bytes, segment then LED byte per digit, digit 0 first
    function automatic logic [15:0][7:0] expect_frame (input logic [23:0] word,
                                                       input logic [7:0] kb, input logic s0);
        logic [31:0]      digits;
        logic [7:0]       leds;
        logic [15:0][7:0] bytes;
        digits = {kb, word};                       // Keys on the two left digits
        leds   = s0 ? kb : word [23:16];
        for (int d = 0; d < 8; d++)
        begin
            bytes [2 * d]     = seg_font [digits [4 * d +: 4]];
            bytes [2 * d + 1] = {7'd0, leds [d]};
        end
        return bytes;
    endfunction

    // Key k in read byte k mod 4, bit 0 or 4, other bits junk
    function automatic logic [31:0] key_scan (input logic [7:0] k);
        logic [31:0] w;
        w = $urandom;
        for (int i = 0; i < 8; i++)
            w [8 * (i % 4) + 4 * (i / 4)] = k [i];
        return w;
    endfunction

    // ------------------------------
    // INMP441 model

    always @(negedge mic_sck)
    begin
        #2;
        if (ws_prev && ! mic_ws)
        begin
            mic_bit = 0;                           // Left slot opens
            tx_word = mic_word;
        end
        else
            mic_bit = mic_bit + 1;
        ws_prev = mic_ws;
        if (! mic_ws && mic_bit >= 1 && mic_bit <= 24)
            mic_sd = tx_word [24 - mic_bit];       // MSB first after one idle bit
        else
            mic_sd = 1'($urandom);                 // Junk outside the word
    end

    // ------------------------------
    // TM1638 model

    always @(negedge sio_stb)
    begin
        if (rst_n)
        begin
            win_open = 1'b1;
            rx_bits  = 0;
            rx_bytes = 0;
            if (win_idx == 3)
                rd_word = key_scan (tm_keys);
        end
    end

    always @(posedge sio_clk)
    begin
        if (win_open && ! sio_stb)
        begin
            rx_sh   = {sio_data, rx_sh [7:1]};     // LSB first
            rx_bits = rx_bits + 1;
            if (rx_bits == 8)
            begin
                rx_q.push_back (rx_sh);
                rx_bits  = 0;
                rx_bytes = rx_bytes + 1;
            end
            if (win_idx == 3 && rx_bytes == 5)
                tm_drive = 1'b0;                   // Last key bit taken
        end
    end

    always @(negedge sio_clk)
    begin
        #2;
        if (win_open && ! sio_stb && win_idx == 3 && rx_bytes >= 1)
        begin
            tm_drive = 1'b1;
            tm_bit   = rd_word [8 * (rx_bytes - 1) + rx_bits];
        end
    end

    always @(posedge sio_stb)
    begin
        if (win_open)
        begin
            win_open          = 1'b0;
            tm_drive          = 1'b0;
            win_len [win_idx] = rx_bytes;
            if (win_idx == 3)
            begin
                win_idx  = 0;
                frame_rx = rx_q;
                rx_q.delete ();
                -> frame_done;
            end
            else
                win_idx = win_idx + 1;
        end
    end

    // ------------------------------
    // Compare process

    always
    begin : compare_frames
        logic [15:0][7:0] exp_bytes;
        @(frame_done);
        check ("window 1 length", 1, win_len [0]);
        check ("window 2 length", 17, win_len [1]);
        check ("window 3 length", 1, win_len [2]);
        check ("window 4 length", 5, win_len [3]);
        check ("frame byte count", 24, frame_rx.size ());
        check ("write command", tm_write, frame_rx [0]);
        check ("address command", tm_addr, frame_rx [1]);
        check ("display command", tm_ctrl, frame_rx [18]);
        check ("read command", tm_read, frame_rx [19]);
        if (check_req)
        begin
            exp_bytes = expect_frame (exp_word, exp_keys, exp_s0);
            for (int i = 0; i < 16; i++)
                check ($sformatf ("%s data byte %0d", case_name, i), exp_bytes [i],
                       frame_rx [2 + i]);
            check_req = 1'b0;
            -> checked;
        end
    end

    // ------------------------------
    // Test sequence

    task automatic check_reset ();
        check ("reset mic_ws", 0, mic_ws);
        check ("reset mic_sck", 0, mic_sck);
        check ("reset mic_lr", 0, mic_lr);
        check ("reset valid", 0, mic_valid);
        while (! win_open)                         // Until the first strobe falls
        begin
            check ("reset sio_stb", 1, sio_stb);
            check ("reset sio_clk", 1, sio_clk);
            check ("reset led", 0, led);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_case (input string name, input logic [23:0] word,
                             input logic [7:0] tmk, input logic [w_key - 1:0] onb,
                             input logic s0);
        logic [7:0] onb_set;
        logic [7:0] kb;
        onb_set              = '0;
        onb_set [w_key - 1:0] = ~ onb;             // Pressed key reads low
        kb                   = tmk | onb_set;
        @(posedge clk);
        #2;
        mic_word = word;
        tm_keys  = tmk;
        key      = onb;
        sw       = {(w_sw - 1)'($urandom), s0};
        repeat (2) @(posedge mic_valid);           // One whole word delivered
        repeat (2) @(frame_done);                  // Keys read and frame relatched
        #1;
        case_name = name;
        exp_word  = word;
        exp_keys  = kb;
        exp_s0    = s0;
        check_req = 1'b1;
        @(checked);
        check ({name, " led"}, s0 ? kb : word [23:16], led);
    endtask

    initial
    begin : main
        void'($urandom (32'h5eb8));
        rst_n    = 1'b0;
        key      = '1;
        sw       = '0;
        mic_word = '0;
        tm_keys  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset ();
        run_case ("sample only", 24'($urandom), 8'h00, 2'b11, 1'b0);
        run_case ("tm keys digits", 24'($urandom), 8'($urandom), 2'b11, 1'b0);
        run_case ("tm keys led", 24'($urandom), 8'($urandom), 2'b11, 1'b1);
        run_case ("onboard key 0", 24'($urandom), 8'($urandom), 2'b10, 1'b1);
        run_case ("onboard keys both", 24'($urandom), 8'h00, 2'b00, 1'b1);
        for (int i = 0; i < 3; i++)
            run_case ($sformatf ("random %0d", i), 24'($urandom), 8'($urandom),
                      w_key'($urandom), 1'($urandom));
        $display ("=== PASS ===");
        $finish;
    end

    // Ten frame periods per test plus a margin
    initial
    begin : watchdog
        #(n_tests * 10 * frame_clocks * 20 + 50000);
        $display ("timeout: the tests did not finish in time");
        $display ("=== FAIL ===");
        $fatal (1, "watchdog expired");
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock
# (
    parameter int period = 20                      // ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~ clk;
    end

endmodule

//--- design/board_pkg.sv
package board_pkg;

    // ------------------------------
    // Peripheral widths

    localparam int w_tm_digit = 8;                 // TM1638 7-segment digits
    localparam int w_tm_led   = 8;                 // TM1638 red LEDs
    localparam int w_tm_key   = 8;                 // TM1638 keys
    localparam int w_mic      = 24;                // INMP441 sample bits

    // ------------------------------
    // TM1638 command bytes and controller states

    typedef enum logic [7:0] {
        cmd_write_auto = 8'h40,                    // Data write, auto increment
        cmd_read_keys  = 8'h42,                    // Key scan read
        cmd_addr_base  = 8'hc0,                    // Display RAM address 0
        cmd_display_on = 8'h8f                     // Display on, max brightness
    } tm_cmd_t;

    typedef enum logic [2:0] {
        st_idle,                                   // Out of reset, bus idle
        st_cmd,                                    // Write mode command
        st_addr,                                   // Start address
        st_data,                                   // Sixteen display bytes
        st_ctrl,                                   // Display control
        st_read_cmd,                               // Key read command
        st_read,                                   // Four key bytes in
        st_gap                                     // Pause between frames
    } tm_state_t;

    // ------------------------------
    // Bundles between blocks

    typedef struct packed {
        logic [w_tm_digit - 1:0][7:0] seg;         // Digit 0 rightmost, bit 0 = a, bit 7 = dot
        logic [w_tm_led   - 1:0]      led;         // One bit per TM1638 LED
    } tm_frame_t;

    typedef struct packed {
        logic signed [w_mic - 1:0] value;          // Left channel, two's complement
        logic                      valid;          // One cycle strobe
    } mic_sample_t;

    // Active high segment font, hgfedcba order
    function automatic logic [7:0] hex_to_seg (input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'h3f;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5b;
            4'h3:    return 8'h4f;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6d;
            4'h6:    return 8'h7d;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7f;
            4'h9:    return 8'h6f;
            4'ha:    return 8'h77;
            4'hb:    return 8'h7c;                 // Lower case b
            4'hc:    return 8'h39;
            4'hd:    return 8'h5e;                 // Lower case d
            4'he:    return 8'h79;
            default: return 8'h71;                 // F
        endcase
    endfunction

endpackage

//--- design/board_specific_top.sv
`timescale 1ns/100ps

module board_specific_top
# (
    parameter clk_mhz = 50,
              sio_div = clk_mhz,                   // 500 kHz TM1638 bit clock
              sck_div = clk_mhz / 6,               // About 3 MHz I2S bit clock
              w_key   = 2,
              w_sw    = 4,
              w_led   = 8
)
(
    input                clk,
    input                rst_n,

    input  [w_key - 1:0] key,                      // Onboard keys, active low
    input  [w_sw  - 1:0] sw,
    output [w_led - 1:0] led,                      // Onboard LEDs

    output               sio_clk,                  // TM1638 bus
    output               sio_stb,
    inout                sio_data,

    output               mic_sck,                  // INMP441 pins
    output               mic_ws,
    output               mic_lr,
    input                mic_sd
);

    import board_pkg::*;

    // ------------------------------

    logic [w_tm_key - 1:0] tm_key;                 // Keys scanned by the TM1638
    logic [w_tm_key - 1:0] key_byte;               // Merged key set for user logic
    tm_frame_t             frame;
    mic_sample_t           sample;

    logic                  sio_dout;
    logic                  sio_oe;
    logic                  sio_din;

    // ------------------------------
    // Onboard keys duplicate the low TM1638 keys

    always_comb
    begin
        key_byte                = tm_key;
        key_byte [w_key - 1:0]  = key_byte [w_key - 1:0] | ~ key;   // Pressed reads as 0
    end

    assign led = frame.led [w_led - 1:0];          // Same byte as TM1638 LEDs

    // Open data line, released while keys are read
    assign sio_data = sio_oe ? sio_dout : 1'bz;
    assign sio_din  = sio_data;

    // ------------------------------

    top
    # (
        .w_sw     ( w_sw     )
    )
    i_top
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .sw       ( sw       ),
        .key_byte ( key_byte ),
        .sample   ( sample   ),
        .frame    ( frame    )
    );

    tm1638_board_controller
    # (
        .sio_div  ( sio_div  )
    )
    i_ledkey
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .frame    ( frame    ),
        .keys     ( tm_key   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_dout ( sio_dout ),
        .sio_oe   ( sio_oe   ),
        .sio_din  ( sio_din  )
    );

    inmp441_mic_i2s_receiver
    # (
        .sck_div  ( sck_div  )
    )
    i_microphone
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .sd       ( mic_sd   ),
        .sck      ( mic_sck  ),
        .ws       ( mic_ws   ),
        .lr       ( mic_lr   ),
        .sample   ( sample   )
    );

endmodule

//--- design/inmp441_mic_i2s_receiver.sv
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver
# (
    parameter sck_div = 8                          // Clocks per half SCK
)
(
    input                                clk,
    input                                rst_n,

    input                                sd,       // Serial data from the mic
    output logic                         sck,
    output logic                         ws,       // Low = left slot
    output logic                         lr,       // Channel select pin
    output board_pkg::mic_sample_t       sample
);

    import board_pkg::*;

    // ------------------------------

    localparam int w_div       = sck_div > 1 ? $clog2 (sck_div) : 1;
    localparam int n_slot_bits = 32;               // Bit periods per channel

    logic [w_div - 1:0] div_cnt;
    logic               tick;                      // SCK edge due
    logic [5:0]         slot;                      // Bit period in the 64 bit frame
    logic               primed;                    // Seen a full frame start
    logic               capture;
    logic               word_done;
    logic [w_mic - 1:0] shift_q;
    logic [w_mic - 1:0] value_q;
    logic               valid_q;

    assign lr = 1'b0;                              // Mic answers in the left slot
    assign ws = slot [5];                          // Flips when slot wraps 31 or 63

    assign tick      = (div_cnt == w_div' (sck_div - 1));
    assign capture   = tick & ~ sck & ~ ws & (slot >= 6'd1) & (slot <= 6' (w_mic));
    assign word_done = tick & sck & primed & (slot == 6' (n_slot_bits - 1));   // WS about to rise

    assign sample    = {value_q, valid_q};

    // ------------------------------
    // SCK and slot counting

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (! rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            slot    <= '0;
            primed  <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= word_done;

            if (tick)
            begin
                div_cnt <= '0;
                sck     <= ~ sck;

                if (sck)                           // Falling edge opens a bit period
                begin
                    slot <= slot + 1'b1;

                    if (slot == 6'd63)
                        primed <= 1'b1;            // Next left slot is whole
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // Left word capture, MSB first

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_q <= {shift_q [w_mic - 2:0], sd};

        if (word_done)
            value_q <= shift_q;
    end

endmodule

//--- design/tm1638_board_controller.sv
`timescale 1ns/100ps

module tm1638_board_controller
# (
    parameter sio_div = 25                         // Clocks per half bit
)
(
    input                                     clk,
    input                                     rst_n,

    input  board_pkg::tm_frame_t              frame,
    output logic [board_pkg::w_tm_key - 1:0]  keys,

    output logic                              sio_clk,
    output logic                              sio_stb,
    output logic                              sio_dout,
    output logic                              sio_oe,   // Low while keys are read
    input                                     sio_din
);

    import board_pkg::*;

    // ------------------------------

    localparam int w_div      = sio_div > 1 ? $clog2 (sio_div) : 1;
    localparam int n_rd_bytes = 4;                 // Key scan bytes per read

    typedef enum logic [1:0] {
        ws_shift,                                  // Lead, bytes and pauses
        ws_tail,                                   // Last half bit before STB rises
        ws_space                                   // STB high between windows
    } win_step_t;

    logic [w_div - 1:0]          div_cnt;
    logic                        tick;             // End of a half bit
    tm_state_t                   state;
    win_step_t                   step;
    logic [4:0]                  bit_cnt;          // 0..15 half bits, 16 = clock parked high
    logic [4:0]                  bit_nxt;
    logic [3:0]                  byte_cnt;
    logic                        win_end;          // Current byte closes the window
    logic                        frame_start;
    logic                        rd_rise;
    logic [7:0]                  tx_byte;
    tm_frame_t                   frame_q;          // Frame frozen for one refresh
    logic [8 * n_rd_bytes - 1:0] key_sr;
    logic [w_tm_key - 1:0]       keys_rx;

    // ------------------------------
    // Half bit timebase

    assign tick = (div_cnt == w_div' (sio_div - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (! rst_n)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign bit_nxt     = (bit_cnt == 5'd16) ? 5'd0 : bit_cnt + 5'd1;
    assign frame_start = tick & (state == st_idle | (state == st_gap & bit_cnt == 5'd15));
    assign rd_rise     = tick & (step == ws_shift) & ~ sio_clk & (state == st_read);

    // ------------------------------
    // Byte on the wire

    always_comb
    begin
        case (state)
            st_cmd:      tx_byte = cmd_write_auto;
            st_addr:     tx_byte = cmd_addr_base;
            st_data:     tx_byte = byte_cnt [0]                          // Even seg, odd LED
                                   ? {7'd0, frame_q.led [byte_cnt [3:1]]}
                                   : frame_q.seg [byte_cnt [3:1]];
            st_ctrl:     tx_byte = cmd_display_on;
            st_read_cmd: tx_byte = cmd_read_keys;
            default:     tx_byte = 8'h00;
        endcase
    end

    always_comb
    begin
        case (state)
            st_data:              win_end = (byte_cnt == 4'd15);
            st_read:              win_end = (byte_cnt == 4' (n_rd_bytes - 1));
            st_addr, st_read_cmd: win_end = 1'b0;    // Data follows in same window
            default:              win_end = 1'b1;
        endcase
    end

    // Key k in read byte k mod 4, bit 0 or bit 4
    always_comb
    begin
        for (int k = 0; k < w_tm_key; k++)
            keys_rx [k] = key_sr [8 * (k % n_rd_bytes) + 4 * (k / n_rd_bytes)];
    end

    // ------------------------------
    // Frame sequencer

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (! rst_n)
        begin
            state    <= st_idle;
            step     <= ws_shift;
            bit_cnt  <= 5'd16;
            byte_cnt <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_dout <= 1'b1;
            sio_oe   <= 1'b1;
            keys     <= '0;
        end
        else if (frame_start)
        begin
            state    <= st_cmd;                    // STB falls, clock stays high
            step     <= ws_shift;
            bit_cnt  <= 5'd16;
            byte_cnt <= '0;
            sio_stb  <= 1'b0;
        end
        else if (tick && state == st_gap)
        begin
            bit_cnt  <= bit_nxt;
        end
        else if (tick)
        begin
            case (step)
                ws_shift:
                begin
                    if (! sio_clk)
                    begin
                        sio_clk <= 1'b1;           // Rising edge, data stable
                        bit_cnt <= bit_nxt;
                    end
                    else if (bit_cnt == 5'd15)     // Byte done
                    begin
                        bit_cnt <= 5'd16;

                        if (win_end)
                        begin
                            step <= ws_tail;

                            if (state == st_read)
                            begin
                                keys   <= keys_rx;
                                sio_oe <= 1'b1;    // Take the line back
                            end
                        end
                        else if (state == st_addr)
                        begin
                            state    <= st_data;
                            byte_cnt <= '0;
                        end
                        else if (state == st_read_cmd)
                        begin
                            state    <= st_read;
                            byte_cnt <= '0;
                            sio_oe   <= 1'b0;      // TM1638 drives from here
                        end
                        else
                        begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    else
                    begin
                        sio_clk  <= 1'b0;          // Falling edge, next bit out
                        bit_cnt  <= bit_nxt;
                        sio_dout <= tx_byte [bit_nxt [3:1]];     // LSB first
                    end
                end

                ws_tail:
                begin
                    sio_stb <= 1'b1;
                    step    <= ws_space;
                end

                default:                           // ws_space
                begin
                    step     <= ws_shift;
                    byte_cnt <= '0;
                    sio_stb  <= (state == st_read);               // Gap keeps STB high
                    bit_cnt  <= (state == st_read) ? 5'd0 : 5'd16;

                    case (state)
                        st_cmd:  state <= st_addr;
                        st_data: state <= st_ctrl;
                        st_ctrl: state <= st_read_cmd;
                        default: state <= st_gap;
                    endcase
                end
            endcase
        end
    end

    // ------------------------------
    // Frame latch and key shifter

    always_ff @(posedge clk)
    begin
        if (frame_start)
            frame_q <= frame;

        if (rd_rise)
            key_sr <= {sio_din, key_sr [8 * n_rd_bytes - 1:1]};   // LSB arrives first
    end

endmodule

//--- design/top.sv
`timescale 1ns/100ps

module top
# (
    parameter w_sw = 4
)
(
    input                                    clk,
    input                                    rst_n,

    input        [w_sw                - 1:0] sw,
    input        [board_pkg::w_tm_key - 1:0] key_byte,   // TM1638 keys ORed with onboard
    input  board_pkg::mic_sample_t           sample,

    output board_pkg::tm_frame_t             frame
);

    import board_pkg::*;

    // ------------------------------

    localparam int n_mic_digits = w_mic / 4;       // Six hex digits per sample
    localparam int n_key_digits = w_tm_key / 4;    // Two hex digits for keys

    logic signed [w_mic - 1:0] value_q;            // Last captured sample

    // Hold the sample between strobes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (! rst_n)
            value_q <= '0;
        else if (sample.valid)
            value_q <= sample.value;
    end

    // ------------------------------
    // Display frame

    always_comb
    begin
        for (int i = 0; i < n_mic_digits; i++)
            frame.seg [i] = hex_to_seg (value_q [4 * i +: 4]);      // Sample on the right

        for (int i = 0; i < n_key_digits; i++)
            frame.seg [n_mic_digits + i] = hex_to_seg (key_byte [4 * i +: 4]);

        // sw[0] picks the LED source
        if (sw [0])
            frame.led = key_byte;
        else
            frame.led = value_q [w_mic - 1 -: w_tm_led];            // Loudness-ish bar
    end

endmodule

//--- run.sh
#!/bin/sh
# Build the board testbench with Verilator and run it

verilator --binary --timing --assert -Wno-fatal --top-module board_tb -f vlog.f \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vboard_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- vlog.f
design/board_pkg.sv
design/top.sv
design/tm1638_board_controller.sv
design/inmp441_mic_i2s_receiver.sv
design/board_specific_top.sv
bench/tb_clock.sv
bench/board_assert.sv
bench/board_tb.sv
